//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_recon -o tb_recon

status=0
./obj_dir/tb_recon > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation reported a failure (exit status $status)"
    exit 1
fi
echo "simulation finished without a reported failure"
exit 0

//--- sim.f
+incdir+source
source/pix_pkg.sv
source/coef_pkg.sv
source/coeff_dequant.sv
source/idct_4x4.sv
source/recon_out_queue.sv
source/recon_top.sv
test/tb_recon.sv

//--- source/coef_pkg.sv
`include "recon_config.svh"

package coef_pkg;

    // ----------------------------------------
    // Coefficient side types
    // ----------------------------------------

    // One signed level or dequantized coefficient
    typedef logic signed [`RECON_COEF_W-1:0] coef_t;

    // DC and AC quantizer factors
    typedef struct packed {
        logic [`RECON_COEF_W-1:0] dc_q;
        logic [`RECON_COEF_W-1:0] ac_q;
    } quant_t;

    // Raster order, element 0 is DC
    typedef coef_t [15:0] coef_blk_t;

    // Upstream block word
    typedef struct packed {
        coef_blk_t          levels;
        quant_t             q;
        pix_pkg::pix_blk_t  pred;
    } coef_in_t;

endpackage

//--- source/coeff_dequant.sv
`timescale 1ns/1ns

module coeff_dequant
    import coef_pkg::*;
    import pix_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      blk_valid_i,
    input  coef_in_t  blk_i,
    output logic      deq_valid_o,
    output coef_blk_t deq_coef_o,
    output pix_blk_t  deq_pred_o
);

    coef_blk_t scaled;
    coef_blk_t coef_q;
    pix_blk_t  pred_q;
    logic      valid_q;

    // ----------------------------------------
    // Level scaling
    // ----------------------------------------

    // Only the low word of each product is kept
    always_comb begin
        for (int i = 0; i < 16; i++) begin
            if (i == 0) begin
                scaled[i] = coef_t'(blk_i.levels[i] * blk_i.q.dc_q);
            end else begin
                scaled[i] = coef_t'(blk_i.levels[i] * blk_i.q.ac_q);
            end
        end
    end

    // ----------------------------------------
    // Stage registers
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= blk_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (blk_valid_i) begin
            coef_q <= scaled;
            pred_q <= blk_i.pred;
        end
    end

    assign deq_valid_o = valid_q;
    assign deq_coef_o  = coef_q;
    assign deq_pred_o  = pred_q;

endmodule

//--- source/idct_4x4.sv
`timescale 1ns/1ns

`include "recon_config.svh"

module idct_4x4
    import coef_pkg::*;
    import pix_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start_i,
    input  coef_blk_t src_i,
    input  pix_blk_t  pred_i,
    output logic      done_o,
    output pix_blk_t  pix_o
);

    // Fixed point rotation constants scaled by 2^16
    localparam logic signed [17:0] MUL_SIN = 18'sd35468;
    localparam logic signed [17:0] MUL_COS = 18'sd85627;

    logic signed [18:0] tmp_next [16];
    logic signed [18:0] tmp      [16];
    pix_blk_t           pred_q;
    pix_blk_t           pix_next;
    pix_blk_t           pix_q;
    logic [1:0]         stage_vld;

    // Product with a rotation constant and arithmetic shift by 16
    function automatic logic signed [18:0] mul_shift(
        input logic signed [18:0] x,
        input logic signed [17:0] k
    );
        logic signed [36:0] prod;
        prod = x * k;
        return prod[34:16];
    endfunction

    // Saturate a reconstructed sum to the pixel range
    function automatic pix_t clamp_pix(input logic signed [21:0] v);
        pix_t res;
        if (v < PIX_MIN) begin
            res = '0;
        end else if (v > PIX_MAX) begin
            res = '1;
        end else begin
            res = v[`RECON_PIX_W-1:0];
        end
        return res;
    endfunction

    // ----------------------------------------
    // First vertical pass
    // ----------------------------------------

    // Column c lands in tmp row c, so pass two reads it transposed
    for (genvar c = 0; c < 4; c++) begin : g_col
        logic signed [18:0] a0;
        logic signed [18:0] a1;
        logic signed [18:0] a2;
        logic signed [18:0] a3;

        assign a0 = src_i[c] + src_i[c + 8];
        assign a1 = src_i[c] - src_i[c + 8];
        assign a2 = mul_shift(src_i[c + 4], MUL_SIN) - mul_shift(src_i[c + 12], MUL_COS);
        assign a3 = mul_shift(src_i[c + 4], MUL_COS) + mul_shift(src_i[c + 12], MUL_SIN);

        assign tmp_next[4*c + 0] = a0 + a3;
        assign tmp_next[4*c + 1] = a1 + a2;
        assign tmp_next[4*c + 2] = a1 - a2;
        assign tmp_next[4*c + 3] = a0 - a3;
    end

    // Prediction travels with its own block
    always_ff @(posedge clk) begin
        if (start_i) begin
            tmp    <= tmp_next;
            pred_q <= pred_i;
        end
    end

    // ----------------------------------------
    // Second horizontal pass
    // ----------------------------------------

    for (genvar r = 0; r < 4; r++) begin : g_row
        logic signed [20:0] b0;
        logic signed [20:0] b1;
        logic signed [20:0] b2;
        logic signed [20:0] b3;
        logic signed [21:0] v0;
        logic signed [21:0] v1;
        logic signed [21:0] v2;
        logic signed [21:0] v3;

        // Rounding bias rides on the even terms
        assign b0 = tmp[r] + tmp[r + 8] + 21'sd4;
        assign b1 = tmp[r] - tmp[r + 8] + 21'sd4;
        assign b2 = mul_shift(tmp[r + 4], MUL_SIN) - mul_shift(tmp[r + 12], MUL_COS);
        assign b3 = mul_shift(tmp[r + 4], MUL_COS) + mul_shift(tmp[r + 12], MUL_SIN);

        // Residual plus prediction
        assign v0 = ((b0 + b3) >>> 3) + $signed({1'b0, pred_q[4*r + 0]});
        assign v1 = ((b1 + b2) >>> 3) + $signed({1'b0, pred_q[4*r + 1]});
        assign v2 = ((b1 - b2) >>> 3) + $signed({1'b0, pred_q[4*r + 2]});
        assign v3 = ((b0 - b3) >>> 3) + $signed({1'b0, pred_q[4*r + 3]});

        // Every lane saturates on its own value
        assign pix_next[4*r + 0] = clamp_pix(v0);
        assign pix_next[4*r + 1] = clamp_pix(v1);
        assign pix_next[4*r + 2] = clamp_pix(v2);
        assign pix_next[4*r + 3] = clamp_pix(v3);
    end

    always_ff @(posedge clk) begin
        if (stage_vld[0]) begin
            pix_q <= pix_next;
        end
    end

    // ----------------------------------------
    // Done tracking
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_vld <= '0;
        end else begin
            stage_vld <= {stage_vld[0], start_i};
        end
    end

    assign done_o = stage_vld[1];
    assign pix_o  = pix_q;

endmodule

//--- source/pix_pkg.sv
`include "recon_config.svh"

package pix_pkg;

    // ----------------------------------------
    // Pixel side types
    // ----------------------------------------

    // Unsigned sample, 0..255
    typedef logic [`RECON_PIX_W-1:0] pix_t;

    // 4x4 block in raster order
    typedef pix_t [15:0] pix_blk_t;

    // Clamp limits for reconstruction
    localparam int PIX_MIN = 0;
    localparam int PIX_MAX = (1 << `RECON_PIX_W) - 1;

endpackage

//--- source/recon_config.svh
`ifndef RECON_CONFIG_SVH
`define RECON_CONFIG_SVH

// ----------------------------------------
// Datapath widths
// ----------------------------------------

// Coefficient, level and quantizer factor width
`define RECON_COEF_W 16

// Reconstructed pixel width
`define RECON_PIX_W 8

// ----------------------------------------
// Flow control
// ----------------------------------------

// Block slots in the output queue, also the upstream credits after reset
`define RECON_QUEUE_DEPTH 4

// Credits held toward downstream after reset
`define RECON_OUT_CREDITS 2

`endif

//--- source/recon_out_queue.sv
`timescale 1ns/1ns

`include "recon_config.svh"

module recon_out_queue
    import pix_pkg::*;
#(
    parameter int DEPTH = `RECON_QUEUE_DEPTH
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push_i,
    input  pix_blk_t push_data_i,
    input  logic     pix_credit_i,
    output logic     pix_valid_o,
    output pix_blk_t pix_o,
    output logic     blk_credit_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CRD_W = $clog2(`RECON_OUT_CREDITS + 1);

    pix_blk_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    logic [CRD_W-1:0] credits;
    logic             pop;
    logic             pop_q;
    pix_blk_t         data_q;

    // Send only with a queued block and a downstream credit
    assign pop = (fill != '0) && (credits != '0);

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
        if (pop) begin
            data_q <= mem[rd_ptr];
        end
    end

    // ----------------------------------------
    // Pointers, fill level and credits
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            fill    <= '0;
            credits <= CRD_W'(`RECON_OUT_CREDITS);
            pop_q   <= 1'b0;
        end else begin
            pop_q <= pop;
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_i, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            // A returned credit and a send in one cycle cancel out
            case ({pix_credit_i, pop})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Freed slot goes back upstream as the block leaves
    assign pix_valid_o  = pop_q;
    assign blk_credit_o = pop_q;
    assign pix_o        = data_q;

endmodule

//--- source/recon_top.sv
`timescale 1ns/1ns

module recon_top
    import coef_pkg::*;
    import pix_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    // Upstream side
    input  logic     blk_valid_i,
    input  coef_in_t blk_i,
    output logic     blk_credit_o,

    // Downstream side
    output logic     pix_valid_o,
    output pix_blk_t pix_o,
    input  logic     pix_credit_i
);

    logic      deq_valid;
    coef_blk_t deq_coef;
    pix_blk_t  deq_pred;
    logic      idct_done;
    pix_blk_t  idct_pix;

    // ----------------------------------------
    // Dequantize, one cycle
    // ----------------------------------------

    coeff_dequant u_dequant (
        .clk         (clk),
        .rst_n       (rst_n),
        .blk_valid_i (blk_valid_i),
        .blk_i       (blk_i),
        .deq_valid_o (deq_valid),
        .deq_coef_o  (deq_coef),
        .deq_pred_o  (deq_pred)
    );

    // ----------------------------------------
    // Inverse transform, two cycles
    // ----------------------------------------

    idct_4x4 u_idct (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (deq_valid),
        .src_i   (deq_coef),
        .pred_i  (deq_pred),
        .done_o  (idct_done),
        .pix_o   (idct_pix)
    );

    // Output queue and credit handling
    recon_out_queue u_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .push_i       (idct_done),
        .push_data_i  (idct_pix),
        .pix_credit_i (pix_credit_i),
        .pix_valid_o  (pix_valid_o),
        .pix_o        (pix_o),
        .blk_credit_o (blk_credit_o)
    );

endmodule

//--- test/recon_tests.txt
// Columns: levels (elements 15..0)  dc_q,ac_q  prediction (15..0)  expected (15..0)
// Zero levels, output equals prediction
0000000000000000000000000000000000000000000000000000000000000000 00010001 F0E1D2C3B4A5968778695A4B3C2D1E0F F0E1D2C3B4A5968778695A4B3C2D1E0F
// DC only, +5 and -4, then clamping per lane
0000000000000000000000000000000000000000000000000000000000000005 00080003 4F4E4D4C4B4A49484746454443424140 54535251504F4E4D4C4B4A4948474645
000000000000000000000000000000000000000000000000000000000000FFFD 000A0003 02F002F002F002F002F002F002F002F0 00EC00EC00EC00EC00EC00EC00EC00EC
0000000000000000000000000000000000000000000000000000000000000005 00080003 FE10FE10FE10FE10FE10FE10FE10FE10 FF15FF15FF15FF15FF15FF15FF15FF15
// Mixed DC and AC
0000000000000000000000000000000000000000000000080000000000080002 00080008 80808080808080808080808080808080 6D737C82737A82887C828B9182889197
// Large AC, lanes saturate independently
0000000000000000000000000000000000000000000000000000001900000000 00100028 4040404040404040C0C0C0C0C0C0C0C0 BD0000BDBD0000BDFF4343FFFF4343FF
// Large DC, full saturation low and high
000000000000000000000000000000000000000000000000000000000000FF9C 00640001 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 00000000000000000000000000000000
0000000000000000000000000000000000000000000000000000000000000064 00640001 00000000000000000000000000000000 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
// Single odd AC term, horizontal then vertical
0000000000000000000000000000000000000000000000000000000000080000 00010008 80808080808080808080808080808080 767C848A767C848A767C848A767C848A
0000000000000000000000000000000000000000000000080000000000000000 00010008 80808080808080808080808080808080 767676767C7C7C7C848484848A8A8A8A

//--- test/tb_recon.sv
`timescale 1ns/1ns

`include "recon_config.svh"

module tb_recon
    import coef_pkg::*;
    import pix_pkg::*;
();

    localparam int          NUM_VEC   = 10;
    localparam int          NUM_SENDS = 3 * NUM_VEC;
    localparam int          TIMEOUT   = 2000;
    localparam logic [15:0] LFSR_SEED = 16'd44341;

    logic     clk;
    logic     rst_n;
    logic     blk_valid_i;
    coef_in_t blk_i;
    logic     blk_credit_o;
    logic     pix_valid_o;
    pix_blk_t pix_o;
    logic     pix_credit_i;

    // Four words per vector for levels, factors, prediction and expected pixels
    logic [255:0] vec_mem [4*NUM_VEC];

    pix_blk_t    exp_q [$];
    logic [15:0] lfsr;
    logic        return_en;
    int          up_credits;
    int          sent_cnt;
    int          recv_cnt;
    int          returned_cnt;
    int          owed;
    int          credit_pulses;
    int          vec_idx;
    int          send_limit;

    recon_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .blk_valid_i  (blk_valid_i),
        .blk_i        (blk_i),
        .blk_credit_o (blk_credit_o),
        .pix_valid_o  (pix_valid_o),
        .pix_o        (pix_o),
        .pix_credit_i (pix_credit_i)
    );

    always #20 clk = ~clk;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] nxt;
        nxt = s >> 1;
        if (s[0]) begin
            nxt = nxt ^ 16'hB400;
        end
        return nxt;
    endfunction

    function automatic coef_in_t build_block(input int k);
        coef_in_t b;
        b.levels = vec_mem[4*k];
        b.q      = vec_mem[4*k + 1][31:0];
        b.pred   = vec_mem[4*k + 2][127:0];
        return b;
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_pix(input string name, input pix_blk_t got, input pix_blk_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_credit(input string name, input int got, input int exp);
        if (got != exp) begin
            stop_on_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    // One clock that samples outputs from before the edge and then drives
    task automatic run_cycle();
        pix_blk_t exp_pix;
        @(posedge clk);
        if (pix_valid_o) begin
            if (exp_q.size() == 0) begin
                stop_on_error("a block was delivered while none was outstanding");
            end
            if (recv_cnt >= `RECON_OUT_CREDITS + returned_cnt) begin
                stop_on_error("a block was delivered without a downstream credit");
            end
            exp_pix = exp_q.pop_front();
            check_pix("pix_o", pix_o, exp_pix);
            recv_cnt++;
            owed++;
        end
        if (blk_credit_o) begin
            up_credits++;
            credit_pulses++;
        end
        if (up_credits > `RECON_QUEUE_DEPTH) begin
            stop_on_error("upstream holds more credits than the queue has slots");
        end

        // Downstream side returns credits at random
        pix_credit_i <= 1'b0;
        if (return_en && owed > 0) begin
            if (lfsr[0]) begin
                pix_credit_i <= 1'b1;
                owed--;
                returned_cnt++;
            end
            lfsr = lfsr_step(lfsr);
        end

        blk_valid_i <= 1'b0;
        if (up_credits > 0 && sent_cnt < send_limit) begin
            blk_i       <= build_block(vec_idx);
            blk_valid_i <= 1'b1;
            exp_q.push_back(pix_blk_t'(vec_mem[4*vec_idx + 3][127:0]));
            vec_idx = (vec_idx + 1) % NUM_VEC;
            up_credits--;
            sent_cnt++;
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin
        int cycles;
        clk           = 1'b0;
        rst_n         = 1'b0;
        blk_valid_i   = 1'b0;
        blk_i         = '0;
        pix_credit_i  = 1'b0;
        lfsr          = LFSR_SEED;
        return_en     = 1'b0;
        up_credits    = `RECON_QUEUE_DEPTH;
        sent_cnt      = 0;
        recv_cnt      = 0;
        returned_cnt  = 0;
        owed          = 0;
        credit_pulses = 0;
        vec_idx       = 0;
        send_limit    = 0;
        $readmemh("test/recon_tests.txt", vec_mem);

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // Nothing may come out while idle after reset
        repeat (8) run_cycle();
        check_credit("blk_credit_o pulses", credit_pulses, 0);

        // Queue fills up while no downstream credit returns
        send_limit = NUM_SENDS;
        repeat (40) run_cycle();
        check_credit("blocks delivered", recv_cnt, `RECON_OUT_CREDITS);
        check_credit("blocks queued", sent_cnt - recv_cnt, `RECON_QUEUE_DEPTH);
        check_credit("upstream credits", up_credits, 0);

        // Random credit return until every block is out
        return_en = 1'b1;
        cycles    = 0;
        while (sent_cnt < send_limit || recv_cnt < sent_cnt) begin
            if (cycles == TIMEOUT) begin
                stop_on_error("timeout while waiting for all blocks to be delivered");
            end
            run_cycle();
            cycles++;
        end

        // Nothing extra may appear afterwards
        repeat (20) run_cycle();
        check_credit("blocks delivered", recv_cnt, NUM_SENDS);
        check_credit("blk_credit_o pulses", credit_pulses, recv_cnt);
        check_credit("upstream credits", up_credits, `RECON_QUEUE_DEPTH);
        check_credit("blocks outstanding", exp_q.size(), 0);

        $display("all tests passed");
        $finish;
    end

endmodule
